/* logic/ethInitSequencer.sv */
// KSZ8851 initialization FSM issuing register commands and reporting initOK
`timescale 1ns/1ps
`default_nettype none
`include "ethInit_defines.svh"

module ethInitSequencer (
    input  wire                    sysclk,
    input  wire                    reset,
    input  wire                    initReq,    // Chip came out of reset
    output logic                   initAck,
    output logic                   cmdReq,
    input  wire                    cmdAck,
    input  wire                    readValid,
    output logic                   isWrite,    // 0 read, 1 write
    output ethPkg::kszAddr_t       regAddr,
    output ethPkg::kszWord_t       writeData,
    input  wire ethPkg::kszWord_t  readData,
    output logic                   initOK
);

    ethPkg::initState_t state;
    ethPkg::initState_t returnState;   // Where the shared wait pair goes next
    ethPkg::initState_t nextReturn;
    logic               initReqD;
    logic               startInit;
    logic               issue;
    logic               nextWrite;
    ethPkg::kszAddr_t   nextAddr;
    ethPkg::kszWord_t   nextData;

    // A fresh init request restarts the sequence from any state
    assign startInit = initReq && ((state == ethPkg::stIdle) || !initReqD);

    // Command decode for the issue states
    always_comb
    begin
        issue      = 1'b1;
        nextWrite  = 1'b1;
        nextAddr   = '0;
        nextData   = '0;
        nextReturn = ethPkg::stIdle;
        if (startInit)
        begin
            nextWrite  = 1'b0;
            nextAddr   = `KSZ_REG_CHIP_ID;
            nextReturn = ethPkg::stCheckChipId;
        end
        else
        begin
            case (state)
                ethPkg::stMacLow:
                begin
                    nextAddr   = `KSZ_REG_MAC_LOW;
                    nextData   = `KSZ_VAL_MAC_LOW;
                    nextReturn = ethPkg::stMacMid;
                end
                ethPkg::stMacMid:
                begin
                    nextAddr   = `KSZ_REG_MAC_MID;
                    nextData   = `KSZ_VAL_MAC_MID;
                    nextReturn = ethPkg::stMacHigh;
                end
                ethPkg::stMacHigh:
                begin
                    nextAddr   = `KSZ_REG_MAC_HIGH;
                    nextData   = `KSZ_VAL_MAC_HIGH;
                    nextReturn = ethPkg::stTxFdpr;
                end
                ethPkg::stTxFdpr:
                begin
                    nextAddr   = `KSZ_REG_TXFDPR;
                    nextData   = `KSZ_VAL_TXFDPR;
                    nextReturn = ethPkg::stTxCr;
                end
                ethPkg::stTxCr:
                begin
                    nextAddr   = `KSZ_REG_TXCR;
                    nextData   = `KSZ_VAL_TXCR;
                    nextReturn = ethPkg::stRxFdpr;
                end
                ethPkg::stRxFdpr:
                begin
                    nextAddr   = `KSZ_REG_RXFDPR;
                    nextData   = `KSZ_VAL_RXFDPR;
                    nextReturn = ethPkg::stRxFctr;
                end
                ethPkg::stRxFctr:
                begin
                    nextAddr   = `KSZ_REG_RXFCTR;
                    nextData   = `KSZ_VAL_RXFCTR;
                    nextReturn = ethPkg::stRxCr1;
                end
                ethPkg::stRxCr1:
                begin
                    nextAddr   = `KSZ_REG_RXCR1;
                    nextData   = `KSZ_VAL_RXCR1;
                    nextReturn = ethPkg::stRxQcr;
                end
                ethPkg::stRxQcr:
                begin
                    nextAddr   = `KSZ_REG_RXQCR;
                    nextData   = `KSZ_VAL_RXQCR;
                    nextReturn = ethPkg::stIrqClear;
                end
                ethPkg::stIrqClear:
                begin
                    nextAddr   = `KSZ_REG_ISR;
                    nextData   = `KSZ_VAL_ISR;
                    nextReturn = ethPkg::stIrqEnable;
                end
                ethPkg::stIrqEnable:
                begin
                    nextAddr   = `KSZ_REG_IER;
                    nextData   = `KSZ_VAL_IER;
                    nextReturn = ethPkg::stTxEnRead;
                end
                ethPkg::stTxEnRead:
                begin
                    nextWrite  = 1'b0;
                    nextAddr   = `KSZ_REG_TXCR;
                    nextReturn = ethPkg::stTxEnWrite;
                end
                ethPkg::stTxEnWrite:
                begin
                    issue      = readValid;
                    nextAddr   = `KSZ_REG_TXCR;
                    nextData   = {readData[15:1], 1'b1};  // Set TX enable
                    nextReturn = ethPkg::stRxEnRead;
                end
                ethPkg::stRxEnRead:
                begin
                    nextWrite  = 1'b0;
                    nextAddr   = `KSZ_REG_RXCR1;
                    nextReturn = ethPkg::stRxEnWrite;
                end
                ethPkg::stRxEnWrite:
                begin
                    issue      = readValid;
                    nextAddr   = `KSZ_REG_RXCR1;
                    nextData   = {readData[15:1], 1'b1};  // Set RX enable
                    nextReturn = ethPkg::stDone;
                end
                default: issue = 1'b0;  // Waits, ID check, done and idle
            endcase
        end
    end

    always_ff @(posedge sysclk or negedge reset)
    begin
        if (!reset)
        begin
            state       <= ethPkg::stIdle;
            returnState <= ethPkg::stIdle;
            cmdReq      <= 1'b0;
            isWrite     <= 1'b0;
            initAck     <= 1'b0;
            initOK      <= 1'b0;
            initReqD    <= 1'b0;
        end
        else
        begin
            initReqD <= initReq;
            if (startInit)
            begin
                initAck <= 1'b1;
                initOK  <= 1'b0;
            end
            if (issue)
            begin
                cmdReq      <= 1'b1;
                isWrite     <= nextWrite;
                returnState <= nextReturn;
                state       <= ethPkg::stWaitAck;
            end
            else
            begin
                case (state)
                    ethPkg::stWaitAck:
                    begin
                        if (cmdAck)
                        begin
                            cmdReq <= 1'b0;
                            state  <= ethPkg::stWaitAckClear;
                        end
                    end
                    ethPkg::stWaitAckClear:
                    begin
                        if (!cmdAck)
                            state <= returnState;
                    end
                    ethPkg::stCheckChipId:
                    begin
                        initAck <= 1'b0;  // initReq is long gone by now
                        if (readValid)
                        begin
                            if (readData[15:4] == `KSZ_CHIP_ID_MASKED)
                                state <= ethPkg::stMacLow;
                            else
                                state <= ethPkg::stIdle;  // Wrong chip, stay uninitialized
                        end
                    end
                    ethPkg::stDone:
                    begin
                        initOK <= 1'b1;
                        state  <= ethPkg::stIdle;
                    end
                    default: state <= state;
                endcase
            end
        end
    end

    // Command payload
    always_ff @(posedge sysclk)
    begin
        if (issue)
        begin
            regAddr   <= nextAddr;
            writeData <= nextData;
        end
    end

endmodule

`default_nettype wire

/* logic/ethInit_defines.svh */
// KSZ8851 chip ID, init register addresses and values, MAC words and host-bus timing
`ifndef ETH_INIT_DEFINES_SVH
`define ETH_INIT_DEFINES_SVH

`define KSZ_CHIP_ID_MASKED 12'h887   // Upper 12 bits of CIDER
`define KSZ_REG_CHIP_ID    8'hC0     // CIDER

`define KSZ_REG_MAC_LOW    8'h10     // MARL
`define KSZ_REG_MAC_MID    8'h12     // MARM
`define KSZ_REG_MAC_HIGH   8'h14     // MARH
`define KSZ_VAL_MAC_LOW    16'h9400  // Low byte is the board id, fixed at zero
`define KSZ_VAL_MAC_MID    16'h0E13
`define KSZ_VAL_MAC_HIGH   16'hFA61

`define KSZ_REG_TXFDPR     8'h84     // TX frame data pointer
`define KSZ_VAL_TXFDPR     16'h4000  // Pointer auto increment
`define KSZ_REG_TXCR       8'h70     // TX control
`define KSZ_VAL_TXCR       16'h01EE  // Flow control, CRC, padding
`define KSZ_REG_RXFDPR     8'h86     // RX frame data pointer
`define KSZ_VAL_RXFDPR     16'h4000  // Pointer auto increment
`define KSZ_REG_RXFCTR     8'h9C     // RX frame count threshold
`define KSZ_VAL_RXFCTR     16'h0001  // One frame
`define KSZ_REG_RXCR1      8'h74     // RX control 1
`define KSZ_VAL_RXCR1      16'h7CE0  // Checksums, filtering, flow control, bcast/mcast/ucast
`define KSZ_REG_RXQCR      8'h82     // RX queue command
`define KSZ_VAL_RXQCR      16'h0030  // Frame count threshold and auto-dequeue
`define KSZ_REG_ISR        8'h92     // Interrupt status
`define KSZ_VAL_ISR        16'hFFFF  // Write ones to clear all
`define KSZ_REG_IER        8'h90     // Interrupt enable
`define KSZ_VAL_IER        16'h2000  // Receive interrupt only

`define KSZ_RESET_CYCLES   100       // Chip reset hold time in sysclk cycles
`define KSZ_STROBE_CYCLES  4         // Width of each host-bus strobe

`endif

/* logic/ethPkg.sv */
// Register address and data word types and the init sequencer state type
`default_nettype none

package ethPkg;

    typedef logic [7:0]  kszAddr_t;  // Chip register address
    typedef logic [15:0] kszWord_t;  // Register data word

    typedef enum logic [4:0] {
        stIdle,
        stWaitAck,         // Shared wait for cmdAck
        stWaitAckClear,    // Shared wait for cmdAck low
        stCheckChipId,
        stMacLow,
        stMacMid,
        stMacHigh,
        stTxFdpr,
        stTxCr,
        stRxFdpr,
        stRxFctr,
        stRxCr1,
        stRxQcr,
        stIrqClear,
        stIrqEnable,
        stTxEnRead,        // Read-modify-write of TXCR
        stTxEnWrite,
        stRxEnRead,        // Read-modify-write of RXCR1
        stRxEnWrite,
        stDone
    } initState_t;

endpackage

`default_nettype wire

/* logic/ethSubsystem.sv */
// Top level joining the init sequencer and the KSZ8851 register port
`timescale 1ns/1ps
`default_nettype none

module ethSubsystem (
    input  wire                    sysclk,
    input  wire                    reset,
    input  wire                    restart,
    output logic                   chipRstN,
    output logic                   chipCsN,
    output logic                   chipCmd,
    output logic                   chipWrN,
    output logic                   chipRdN,
    output ethPkg::kszWord_t       chipSdOut,
    output logic                   chipSdOe,
    input  wire ethPkg::kszWord_t  chipSdIn,
    output logic                   initOK
);

    // Init handshake
    logic             initReq;
    logic             initAck;

    // Command interface
    logic             cmdReq;
    logic             cmdAck;
    logic             isWrite;
    ethPkg::kszAddr_t regAddr;
    ethPkg::kszWord_t writeData;
    logic             readValid;
    ethPkg::kszWord_t readData;

    ethInitSequencer i_ethInitSequencer (
        .sysclk    (sysclk),
        .reset     (reset),
        .initReq   (initReq),
        .initAck   (initAck),
        .cmdReq    (cmdReq),
        .cmdAck    (cmdAck),
        .readValid (readValid),
        .isWrite   (isWrite),
        .regAddr   (regAddr),
        .writeData (writeData),
        .readData  (readData),
        .initOK    (initOK)
    );

    kszRegPort i_kszRegPort (
        .sysclk    (sysclk),
        .reset     (reset),
        .restart   (restart),
        .initReq   (initReq),
        .initAck   (initAck),
        .cmdReq    (cmdReq),
        .cmdAck    (cmdAck),
        .isWrite   (isWrite),
        .regAddr   (regAddr),
        .writeData (writeData),
        .readValid (readValid),
        .readData  (readData),
        .chipRstN  (chipRstN),
        .chipCsN   (chipCsN),
        .chipCmd   (chipCmd),
        .chipWrN   (chipWrN),
        .chipRdN   (chipRdN),
        .chipSdOut (chipSdOut),
        .chipSdOe  (chipSdOe),
        .chipSdIn  (chipSdIn)
    );

endmodule

`default_nettype wire

/* logic/kszRegPort.sv */
// KSZ8851 register port with chip reset timer, init request and host-bus cycle engine
`timescale 1ns/1ps
`default_nettype none
`include "ethInit_defines.svh"

module kszRegPort (
    input  wire                    sysclk,
    input  wire                    reset,
    input  wire                    restart,    // Re-run chip reset
    output logic                   initReq,
    input  wire                    initAck,
    input  wire                    cmdReq,
    output logic                   cmdAck,
    input  wire                    isWrite,
    input  wire ethPkg::kszAddr_t  regAddr,
    input  wire ethPkg::kszWord_t  writeData,
    output logic                   readValid,
    output ethPkg::kszWord_t       readData,
    output logic                   chipRstN,
    output logic                   chipCsN,
    output logic                   chipCmd,    // High in address phase
    output logic                   chipWrN,
    output logic                   chipRdN,
    output ethPkg::kszWord_t       chipSdOut,
    output logic                   chipSdOe,   // Data bus driver enable
    input  wire ethPkg::kszWord_t  chipSdIn
);

    localparam int resetCycles  = `KSZ_RESET_CYCLES;
    localparam int strobeCycles = `KSZ_STROBE_CYCLES;
    localparam int busCycles    = 2 * strobeCycles + 2;  // Two phases plus two idle cycles
    localparam int rstCntW      = $clog2(resetCycles + 1);
    localparam int phaseW       = $clog2(busCycles + 1);

    logic [rstCntW-1:0] rstCnt;
    logic               initPend;     // Chip just left reset
    logic               busy;
    logic [phaseW-1:0]  phaseCnt;
    logic               latWrite;
    ethPkg::kszAddr_t   latAddr;
    ethPkg::kszWord_t   latData;
    logic [3:0]         byteEn;
    logic               addrPhase;
    logic               dataPhase;
    logic               sampleNow;
    logic               cycleLast;
    logic               accept;

    // Phase decode from the cycle counter
    assign addrPhase = busy && (phaseCnt < phaseW'(strobeCycles));
    assign dataPhase = busy && (phaseCnt > phaseW'(strobeCycles))
                       && (phaseCnt <= phaseW'(2 * strobeCycles));
    assign sampleNow = busy && (phaseCnt == phaseW'(2 * strobeCycles));  // Last data strobe
    assign cycleLast = busy && (phaseCnt == phaseW'(busCycles - 1));

    // No commands while the chip is in reset or init is still pending
    assign accept = cmdReq && !cmdAck && !busy && chipRstN && !initPend && !initReq;

    assign byteEn = latAddr[1] ? 4'b1100 : 4'b0011;  // Upper or lower word of the dword

    // Chip reset timer and init request
    always_ff @(posedge sysclk or negedge reset)
    begin
        if (!reset)
        begin
            chipRstN <= 1'b0;
            rstCnt   <= '0;
            initPend <= 1'b0;
            initReq  <= 1'b0;
        end
        else if (restart)
        begin
            chipRstN <= 1'b0;  // Hold the chip in reset again
            rstCnt   <= '0;
            initPend <= 1'b0;
            initReq  <= 1'b0;
        end
        else
        begin
            initPend <= 1'b0;
            if (!chipRstN)
            begin
                if (rstCnt == rstCntW'(resetCycles - 1))
                begin
                    chipRstN <= 1'b1;
                    initPend <= 1'b1;
                end
                else
                begin
                    rstCnt <= rstCnt + 1'b1;
                end
            end
            if (initPend)
                initReq <= 1'b1;  // One cycle after chip reset ends
            else if (initAck)
                initReq <= 1'b0;
        end
    end

    // Command handshake and bus cycle sequencing
    always_ff @(posedge sysclk or negedge reset)
    begin
        if (!reset)
        begin
            busy      <= 1'b0;
            phaseCnt  <= '0;
            cmdAck    <= 1'b0;
            readValid <= 1'b0;
        end
        else if (restart)
        begin
            busy      <= 1'b0;  // Abort any cycle in flight
            phaseCnt  <= '0;
            cmdAck    <= 1'b0;
            readValid <= 1'b0;
        end
        else if (accept)
        begin
            cmdAck    <= 1'b1;
            busy      <= 1'b1;
            phaseCnt  <= '0;
            readValid <= 1'b0;  // Old read data no longer valid
        end
        else if (busy)
        begin
            phaseCnt <= phaseCnt + 1'b1;
            if (sampleNow && !latWrite)
                readValid <= 1'b1;
            if (cycleLast)
                busy <= 1'b0;
        end
        else if (cmdAck && !cmdReq)
        begin
            cmdAck <= 1'b0;  // Cycle done and request withdrawn
        end
    end

    // Command fields and captured read data
    always_ff @(posedge sysclk)
    begin
        if (accept)
        begin
            latWrite <= isWrite;
            latAddr  <= regAddr;
            latData  <= writeData;
        end
        if (sampleNow && !latWrite)
            readData <= chipSdIn;
    end

    // Host-bus pins
    assign chipCsN   = !busy;
    assign chipCmd   = addrPhase;
    assign chipWrN   = !(addrPhase || (dataPhase && latWrite));  // Address latch uses WRN too
    assign chipRdN   = !(dataPhase && !latWrite);
    assign chipSdOe  = addrPhase || (dataPhase && latWrite);
    assign chipSdOut = addrPhase ? {byteEn, 4'h0, latAddr} : latData;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the ethSubsystem testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module ethSubsystemTb -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VethSubsystemTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation log holds no result line"
    exit 1
fi
exit 0

/* sim.f */
+incdir+logic
logic/ethPkg.sv
logic/kszRegPort.sv
logic/ethInitSequencer.sv
logic/ethSubsystem.sv
tests/kszChipModel.sv
tests/ethSubsystemTb.sv

/* tests/ethSubsystemTb.sv */
// Testbench for ethSubsystem with chip model, reference write list, bus monitor and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "ethInit_defines.svh"

module ethSubsystemTb;

    localparam int refCount    = 13;  // Writes in one full init
    localparam int perInit     = `KSZ_RESET_CYCLES + 20 * (2 * `KSZ_STROBE_CYCLES + 8);
    localparam int limitCycles = 4 * perInit + 600;  // Four inits plus margin

    logic             sysclk;
    logic             reset;
    logic             restart;
    logic             chipRstN;
    logic             chipCsN;
    logic             chipCmd;
    logic             chipWrN;
    logic             chipRdN;
    ethPkg::kszWord_t chipSdOut;
    logic             chipSdOe;
    ethPkg::kszWord_t chipSdIn;
    logic             initOK;
    logic             badId;
    logic             preloadEn;
    ethPkg::kszAddr_t preloadAddr;
    ethPkg::kszWord_t preloadData;
    ethPkg::kszAddr_t peekAddr;
    ethPkg::kszWord_t peekData;
    logic             accValid;
    logic             accWrite;
    ethPkg::kszAddr_t accAddr;
    ethPkg::kszWord_t accData;
    logic [31:0]      lcgState;
    logic             checkWrites;       // Writes allowed after the ID read
    logic             powerOn;           // No restart issued yet
    int               runId;             // Bumped by every restart
    int               checkErrors;
    int               compRun = 0;
    int               writeIdx = 0;      // Writes seen in the current run
    logic             seenIdRead = 1'b0;
    logic             initOkD = 1'b0;
    logic             addrSeen = 1'b0;
    int               busErrors = 0;
    int               writeErrors = 0;

    ethSubsystem i_ethSubsystem (
        .sysclk    (sysclk),
        .reset     (reset),
        .restart   (restart),
        .chipRstN  (chipRstN),
        .chipCsN   (chipCsN),
        .chipCmd   (chipCmd),
        .chipWrN   (chipWrN),
        .chipRdN   (chipRdN),
        .chipSdOut (chipSdOut),
        .chipSdOe  (chipSdOe),
        .chipSdIn  (chipSdIn),
        .initOK    (initOK)
    );

    kszChipModel chipModel (
        .sysclk      (sysclk),
        .chipRstN    (chipRstN),
        .chipCsN     (chipCsN),
        .chipCmd     (chipCmd),
        .chipWrN     (chipWrN),
        .chipRdN     (chipRdN),
        .chipSdOut   (chipSdOut),
        .chipSdOe    (chipSdOe),
        .chipSdIn    (chipSdIn),
        .badId       (badId),
        .preloadEn   (preloadEn),
        .preloadAddr (preloadAddr),
        .preloadData (preloadData),
        .peekAddr    (peekAddr),
        .peekData    (peekData),
        .accValid    (accValid),
        .accWrite    (accWrite),
        .accAddr     (accAddr),
        .accData     (accData)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Byte lanes of the 16-bit word at a byte address
    function automatic logic [3:0] wordLanes(input ethPkg::kszAddr_t addr);
        return 4'b0011 << (2 * addr[1]);
    endfunction

    // Expected write number idx of one init as {address, data}
    function automatic logic [23:0] refWrite(input int idx);
        logic [23:0] seq [refCount];
        int          j;
        int          k;
        seq[0]  = {`KSZ_REG_MAC_LOW, `KSZ_VAL_MAC_LOW};
        seq[1]  = {`KSZ_REG_MAC_MID, `KSZ_VAL_MAC_MID};
        seq[2]  = {`KSZ_REG_MAC_HIGH, `KSZ_VAL_MAC_HIGH};
        seq[3]  = {`KSZ_REG_TXFDPR, `KSZ_VAL_TXFDPR};
        seq[4]  = {`KSZ_REG_TXCR, `KSZ_VAL_TXCR};
        seq[5]  = {`KSZ_REG_RXFDPR, `KSZ_VAL_RXFDPR};
        seq[6]  = {`KSZ_REG_RXFCTR, `KSZ_VAL_RXFCTR};
        seq[7]  = {`KSZ_REG_RXCR1, `KSZ_VAL_RXCR1};
        seq[8]  = {`KSZ_REG_RXQCR, `KSZ_VAL_RXQCR};
        seq[9]  = {`KSZ_REG_ISR, `KSZ_VAL_ISR};
        seq[10] = {`KSZ_REG_IER, `KSZ_VAL_IER};
        seq[11] = {`KSZ_REG_TXCR, 16'h0000};   // Data filled in below
        seq[12] = {`KSZ_REG_RXCR1, 16'h0000};
        for (k = 11; k < refCount; k++)
            for (j = 0; j < k; j++)
                if (seq[j][23:16] == seq[k][23:16])
                    seq[k][15:0] = seq[j][15:0] | 16'h0001;  // Last value plus enable bit
        return seq[idx];
    endfunction

    task automatic pulseRestart();
        @(negedge sysclk);
        restart = 1'b1;
        runId   = runId + 1;
        powerOn = 1'b0;
        @(negedge sysclk);
        restart = 1'b0;
    endtask

    task automatic waitInitOk();
        while (!initOK)
            @(negedge sysclk);
    endtask

    // Final register value against the last reference write to it
    task automatic checkReg(input string name, input ethPkg::kszAddr_t addr);
        ethPkg::kszWord_t expVal;
        logic [23:0]      entry;
        int               i;
        expVal = '0;
        for (i = 0; i < refCount; i++)
        begin
            entry = refWrite(i);
            if (entry[23:16] == addr)
                expVal = entry[15:0];
        end
        @(negedge sysclk);
        peekAddr = addr;
        @(posedge sysclk);
        if (peekData != expVal)
        begin
            $display("ERROR %s: expected %h, actual %h", name, expVal, peekData);
            checkErrors++;
        end
    endtask

    initial
    begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;  // 4 ns period
    end

    // Bus protocol monitor
    always @(posedge sysclk)
    begin
        if (!chipRstN && (!chipWrN || !chipRdN || !chipCsN || chipCmd || chipSdOe))
        begin
            $display("Bus activity while the chip is held in reset at %0t", $time);
            busErrors++;
        end
        if (!chipRstN && powerOn && initOK)
        begin
            $display("initOK is high during power-on chip reset at %0t", $time);
            busErrors++;
        end
        if (!chipWrN && !chipRdN)
        begin
            $display("Write and read strobes active together at %0t", $time);
            busErrors++;
        end
        if (chipCmd && (chipWrN || chipCsN))
        begin
            $display("Address phase without write strobe or chip select at %0t", $time);
            busErrors++;
        end
        if (chipSdOe != (!chipCsN && !chipWrN))
        begin
            $display("Data bus driver enable does not follow the write strobe at %0t", $time);
            busErrors++;
        end
        if (chipCmd && (chipSdOut[15:12] != wordLanes(chipSdOut[7:0])))
        begin
            $display("ERROR byte enables: expected %h, actual %h",
                     wordLanes(chipSdOut[7:0]), chipSdOut[15:12]);
            busErrors++;
        end
        if (!chipCmd && (!chipWrN || !chipRdN) && !addrSeen)
        begin
            $display("Data phase without a preceding address phase at %0t", $time);
            busErrors++;
        end
        if (chipCmd)
            addrSeen <= 1'b1;
        else if (chipCsN)
            addrSeen <= 1'b0;  // Bus cycle over
    end

    // Write log against the reference list
    always @(posedge sysclk)
    begin
        initOkD <= initOK;
        if ((runId != compRun) || !chipRstN)
        begin
            compRun    <= runId;  // New run or chip reset starts the list again
            writeIdx   <= 0;
            seenIdRead <= 1'b0;
        end
        else if (accValid && !accWrite)
        begin
            if (accAddr == `KSZ_REG_CHIP_ID)
                seenIdRead <= 1'b1;
        end
        else if (accValid)
        begin
            if (!seenIdRead)
            begin
                $display("Register write before the chip ID read at %0t", $time);
                writeErrors++;
            end
            else if (!checkWrites)
            begin
                $display("Register write after a bad chip ID at %0t", $time);
                writeErrors++;
            end
            else if (writeIdx >= refCount)
            begin
                $display("More register writes than one init holds at %0t", $time);
                writeErrors++;
            end
            else if ({accAddr, accData} != refWrite(writeIdx))
            begin
                $display("ERROR write %0d: expected %h, actual %h",
                         writeIdx, refWrite(writeIdx), {accAddr, accData});
                writeErrors++;
            end
            writeIdx <= writeIdx + 1;
        end
        if (initOK && !initOkD && (writeIdx != refCount))
        begin
            $display("ERROR writes before initOK: expected %0d, actual %0d", refCount, writeIdx);
            writeErrors++;
        end
    end

    // Watchdog
    initial
    begin
        repeat (limitCycles) @(posedge sysclk);
        $display("Timeout: the tests did not finish within %0d cycles", limitCycles);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        int restartDelay;
        reset       = 1'b0;
        restart     = 1'b0;
        badId       = 1'b0;
        preloadEn   = 1'b0;
        preloadAddr = '0;
        preloadData = '0;
        peekAddr    = '0;
        checkWrites = 1'b1;
        powerOn     = 1'b1;
        runId       = 0;
        checkErrors = 0;
        lcgState    = 32'he9e68754;
        repeat (16) @(negedge sysclk);
        reset = 1'b1;

        waitInitOk();  // Power-on init
        checkReg("TXCR after power-on init", `KSZ_REG_TXCR);
        checkReg("RXCR1 after power-on init", `KSZ_REG_RXCR1);

        @(negedge sysclk);
        badId       = 1'b1;  // Wrong chip on restart
        checkWrites = 1'b0;
        pulseRestart();
        while (!seenIdRead)
            @(negedge sysclk);
        repeat (4 * (2 * `KSZ_STROBE_CYCLES + 2)) @(negedge sysclk);
        if (initOK !== 1'b0)
        begin
            $display("ERROR initOK after bad chip ID: expected 0, actual %b", initOK);
            checkErrors++;
        end

        @(negedge sysclk);
        badId       = 1'b0;
        checkWrites = 1'b1;
        lcgState    = lcgNext(lcgState);
        preloadEn   = 1'b1;  // Scramble both enable registers
        preloadAddr = `KSZ_REG_TXCR;
        preloadData = lcgState[31:16];
        @(negedge sysclk);
        lcgState    = lcgNext(lcgState);
        preloadAddr = `KSZ_REG_RXCR1;
        preloadData = lcgState[31:16];
        @(negedge sysclk);
        preloadEn = 1'b0;
        pulseRestart();
        lcgState     = lcgNext(lcgState);
        restartDelay = `KSZ_RESET_CYCLES + 5 + int'(lcgState[31:25]);  // Lands inside the init
        repeat (restartDelay) @(negedge sysclk);
        pulseRestart();
        waitInitOk();
        checkReg("TXCR after random restart", `KSZ_REG_TXCR);
        checkReg("RXCR1 after random restart", `KSZ_REG_RXCR1);

        repeat (4) @(negedge sysclk);
        $display("Bus errors %0d, write errors %0d, check errors %0d",
                 busErrors, writeErrors, checkErrors);
        if (busErrors + writeErrors + checkErrors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/kszChipModel.sv */
// Behavioral KSZ8851 host-bus model with register file, preload and peek ports and access report
`timescale 1ns/1ps
`default_nettype none
`include "ethInit_defines.svh"

module kszChipModel (
    input  wire                    sysclk,
    input  wire                    chipRstN,
    input  wire                    chipCsN,
    input  wire                    chipCmd,
    input  wire                    chipWrN,
    input  wire                    chipRdN,
    input  wire ethPkg::kszWord_t  chipSdOut,
    input  wire                    chipSdOe,
    output ethPkg::kszWord_t       chipSdIn,
    input  wire                    badId,        // Answer CIDER with a foreign ID
    input  wire                    preloadEn,    // Backdoor register write
    input  wire ethPkg::kszAddr_t  preloadAddr,
    input  wire ethPkg::kszWord_t  preloadData,
    input  wire ethPkg::kszAddr_t  peekAddr,     // Backdoor register read
    output ethPkg::kszWord_t       peekData,
    output logic                   accValid,     // One pulse per finished access
    output logic                   accWrite,
    output ethPkg::kszAddr_t       accAddr,
    output ethPkg::kszWord_t       accData
);

    logic [7:0]       regFile [256];   // Byte-wide register space
    ethPkg::kszAddr_t curAddr;         // Latched in the address phase
    int               strobeCnt;
    logic             dataStrobe;
    ethPkg::kszWord_t readWord;

    initial
    begin
        for (int i = 0; i < 256; i++)
            regFile[i] = 8'(i * 37 + 11);  // Every byte distinct
        regFile[`KSZ_REG_CHIP_ID]        = 8'h72;  // CIDER reads 0x8872
        regFile[`KSZ_REG_CHIP_ID + 8'd1] = 8'h88;
        strobeCnt = 0;
        accValid  = 1'b0;
    end

    // Data phase strobe, ignored while the chip is in reset
    assign dataStrobe = chipRstN && !chipCsN && !chipCmd
                        && ((!chipWrN && chipSdOe) || !chipRdN);

    always_comb
    begin
        if (badId && (curAddr == `KSZ_REG_CHIP_ID))
            readWord = 16'h1230;  // Not a KSZ8851
        else
            readWord = {regFile[{curAddr[7:1], 1'b1}], regFile[{curAddr[7:1], 1'b0}]};
    end

    assign chipSdIn = !chipRdN ? readWord : '0;  // Drive only during read strobe
    assign peekData = {regFile[{peekAddr[7:1], 1'b1}], regFile[{peekAddr[7:1], 1'b0}]};

    always @(posedge sysclk)
    begin
        accValid <= 1'b0;
        if (chipRstN && !chipCsN && chipCmd && !chipWrN)
            curAddr <= chipSdOut[7:0];  // Byte enables sit in the top nibble
        if (dataStrobe)
            strobeCnt <= strobeCnt + 1;
        else
            strobeCnt <= 0;
        if (dataStrobe && (strobeCnt == `KSZ_STROBE_CYCLES - 1))
        begin
            accValid <= 1'b1;  // Last strobe cycle completes the access
            accWrite <= !chipWrN;
            accAddr  <= curAddr;
            if (!chipWrN)
            begin
                accData                       <= chipSdOut;
                regFile[{curAddr[7:1], 1'b0}] <= chipSdOut[7:0];
                regFile[{curAddr[7:1], 1'b1}] <= chipSdOut[15:8];
            end
            else
            begin
                accData <= chipSdIn;
            end
        end
        if (preloadEn)
        begin
            regFile[{preloadAddr[7:1], 1'b0}] <= preloadData[7:0];
            regFile[{preloadAddr[7:1], 1'b1}] <= preloadData[15:8];
        end
    end

endmodule

`default_nettype wire
